/* hdl/ddr_stat_regs.sv */
`timescale 1ns/100ps

`include "stat_defines.svh"

// DDR status registers answering every request one cycle later
module ddr_stat_regs (
   input  logic                             clk,
   input  logic                             pipe_rst_n,
   stat_req_if.snk                          req,
   input  stat_reg_pkg::ready_bits_t        sh_cl_ddr_is_ready,
   output stat_bus_pkg::stat_ack_t          rsp
);

   logic [`STAT_DATA_W-1:0] scratch_q;
   logic [`STAT_DATA_W-1:0] wr_count_q;
   stat_reg_pkg::int_bits_t int_status_q;
   stat_reg_pkg::int_bits_t int_set;
   stat_reg_pkg::int_bits_t int_clr;
   logic                    ack_q;
   logic [`STAT_DATA_W-1:0] rdata_q;
   logic [`STAT_DATA_W-1:0] rd_mux;

   // ----------------------------------------------------------------------
   // write decode
   // ----------------------------------------------------------------------
   // w1s and w1c masks from the low byte of the write data
   assign int_set = (req.wr && req.addr == stat_reg_pkg::REG_INT_SET) ?
                    req.wdata[`STAT_INT_W-1:0] : '0;
   assign int_clr = (req.wr && req.addr == stat_reg_pkg::REG_INT_STATUS) ?
                    req.wdata[`STAT_INT_W-1:0] : '0;

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         scratch_q    <= '0;
         wr_count_q   <= '0;
         int_status_q <= '0;
      end
      else
      begin
         if (req.wr && req.addr == stat_reg_pkg::REG_SCRATCH)
            scratch_q <= req.wdata;
         // counts every write including read only targets and wraps
         if (req.wr)
            wr_count_q <= wr_count_q + 1;
         // set wins over clear on the same bit
         int_status_q <= (int_status_q & ~int_clr) | int_set;
      end
   end

   // ----------------------------------------------------------------------
   // read mux
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (req.addr)
         stat_reg_pkg::REG_ID:         rd_mux = `DDR_STAT_ID;
         stat_reg_pkg::REG_SCRATCH:    rd_mux = scratch_q;
         // ready bits in the low end with the rest zero
         stat_reg_pkg::REG_READY:
            rd_mux = {{(`STAT_DATA_W-`DDR_READY_W){1'b0}}, sh_cl_ddr_is_ready};
         stat_reg_pkg::REG_WR_COUNT:   rd_mux = wr_count_q;
         stat_reg_pkg::REG_INT_STATUS:
            rd_mux = {{(`STAT_DATA_W-`STAT_INT_W){1'b0}}, int_status_q};
         stat_reg_pkg::REG_INT_SET:    rd_mux = '0;
         default:                      rd_mux = `STAT_BAD_DATA;
      endcase
   end

   // one response per request and writes answer with zero data
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         ack_q   <= 1'b0;
         rdata_q <= '0;
      end
      else
      begin
         ack_q   <= req.wr | req.rd;
         rdata_q <= (req.rd && !req.wr) ? rd_mux : '0;
      end
   end

   assign rsp.ack   = ack_q;
   assign rsp.rdata = rdata_q;
   // live status not tied to ack
   assign rsp.intr  = int_status_q;

endmodule

/* hdl/ddr_stat_top.sv */
`timescale 1ns/100ps

`include "stat_defines.svh"

// stat register path of one DDR channel
// host port -> request pipe -> registers -> ack pipe -> host port
module ddr_stat_top (
   input  logic                        clk,
   input  logic                        pipe_rst_n,
   input  logic                        sh_ddr_stat_wr,
   input  logic                        sh_ddr_stat_rd,
   input  logic [`STAT_ADDR_W-1:0]     sh_ddr_stat_addr,
   input  logic [`STAT_DATA_W-1:0]     sh_ddr_stat_wdata,
   input  stat_reg_pkg::ready_bits_t   sh_cl_ddr_is_ready,
   output logic                        ddr_sh_stat_ack,
   output logic [`STAT_DATA_W-1:0]     ddr_sh_stat_rdata,
   output stat_reg_pkg::int_bits_t     ddr_sh_stat_int
);

   stat_req_if req_host ();
   stat_req_if req_regs ();

   stat_bus_pkg::stat_req_t req_pipe_in;
   stat_bus_pkg::stat_req_t req_pipe_out;
   stat_bus_pkg::stat_ack_t ack_pipe_in;
   stat_bus_pkg::stat_ack_t ack_pipe_out;

   // ----------------------------------------------------------------------
   // host side
   // ----------------------------------------------------------------------
   stat_host_port u_host_port (
      .clk               (clk),
      .pipe_rst_n        (pipe_rst_n),
      .sh_ddr_stat_wr    (sh_ddr_stat_wr),
      .sh_ddr_stat_rd    (sh_ddr_stat_rd),
      .sh_ddr_stat_addr  (sh_ddr_stat_addr),
      .sh_ddr_stat_wdata (sh_ddr_stat_wdata),
      .req               (req_host.src),
      .rsp               (ack_pipe_out),
      .ddr_sh_stat_ack   (ddr_sh_stat_ack),
      .ddr_sh_stat_rdata (ddr_sh_stat_rdata),
      .ddr_sh_stat_int   (ddr_sh_stat_int)
   );

   // pack for the pipe
   assign req_pipe_in.wr    = req_host.wr;
   assign req_pipe_in.rd    = req_host.rd;
   assign req_pipe_in.addr  = req_host.addr;
   assign req_pipe_in.wdata = req_host.wdata;

   // ----------------------------------------------------------------------
   // pipes across the floorplan
   // ----------------------------------------------------------------------
   stat_pipe #(
      .WIDTH  (stat_bus_pkg::STAT_REQ_W),
      .STAGES (`STAT_PIPE_STAGES)
   ) u_req_pipe (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .in_bus     (req_pipe_in),
      .out_bus    (req_pipe_out)
   );

   // unpack at the register end
   assign req_regs.wr    = req_pipe_out.wr;
   assign req_regs.rd    = req_pipe_out.rd;
   assign req_regs.addr  = req_pipe_out.addr;
   assign req_regs.wdata = req_pipe_out.wdata;

   stat_pipe #(
      .WIDTH  (stat_bus_pkg::STAT_ACK_W),
      .STAGES (`STAT_PIPE_STAGES)
   ) u_ack_pipe (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .in_bus     (ack_pipe_in),
      .out_bus    (ack_pipe_out)
   );

   // ----------------------------------------------------------------------
   // register block
   // ----------------------------------------------------------------------
   ddr_stat_regs u_regs (
      .clk                (clk),
      .pipe_rst_n         (pipe_rst_n),
      .req                (req_regs.snk),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .rsp                (ack_pipe_in)
   );

endmodule

/* hdl/stat_bus_pkg.sv */
`include "stat_defines.svh"

// word formats of the stat bus, both directions
package stat_bus_pkg;

   // host side request, one cycle per access
   // field order follows the shell stat port
   typedef struct packed {
      logic                    wr;
      logic                    rd;
      logic [`STAT_ADDR_W-1:0] addr;
      logic [`STAT_DATA_W-1:0] wdata;
   } stat_req_t;

   // response word, ack is a single cycle pulse
   // intr is not qualified by ack
   // rdata only meaningful with ack
   typedef struct packed {
      logic                    ack;
      logic [`STAT_INT_W-1:0]  intr;
      logic [`STAT_DATA_W-1:0] rdata;
   } stat_ack_t;

   // widths of the packed forms, used for pipe sizing
   localparam int STAT_REQ_W = $bits(stat_req_t);
   localparam int STAT_ACK_W = $bits(stat_ack_t);

endpackage

/* hdl/stat_defines.svh */
`ifndef STAT_DEFINES_SVH
`define STAT_DEFINES_SVH

// ----------------------------------------------------------------------
// stat bus geometry
// ----------------------------------------------------------------------
// register stages in each direction, floorplan dependent
`define STAT_PIPE_STAGES 8
`define STAT_ADDR_W      8
`define STAT_DATA_W      32
`define STAT_INT_W       8
// one ready bit per DDR controller
`define DDR_READY_W      3

// ----------------------------------------------------------------------
// fixed read values
// ----------------------------------------------------------------------
`define DDR_STAT_ID      32'h5d1a_0a01
`define STAT_BAD_DATA    32'hdead_da7a

`endif

/* hdl/stat_host_port.sv */
`timescale 1ns/100ps

`include "stat_defines.svh"

// host side of the stat bus
// one register on the way in, one on the way out
module stat_host_port (
   input  logic                         clk,
   input  logic                         pipe_rst_n,
   input  logic                         sh_ddr_stat_wr,
   input  logic                         sh_ddr_stat_rd,
   input  logic [`STAT_ADDR_W-1:0]      sh_ddr_stat_addr,
   input  logic [`STAT_DATA_W-1:0]      sh_ddr_stat_wdata,
   stat_req_if.src                      req,
   input  stat_bus_pkg::stat_ack_t      rsp,
   output logic                         ddr_sh_stat_ack,
   output logic [`STAT_DATA_W-1:0]      ddr_sh_stat_rdata,
   output logic [`STAT_INT_W-1:0]       ddr_sh_stat_int
);

   // ----------------------------------------------------------------------
   // request capture
   // ----------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         req.wr    <= 1'b0;
         req.rd    <= 1'b0;
         req.addr  <= '0;
         req.wdata <= '0;
      end
      else
      begin
         req.wr    <= sh_ddr_stat_wr;
         // write wins, a read in the same cycle is lost
         req.rd    <= sh_ddr_stat_rd & ~sh_ddr_stat_wr;
         req.addr  <= sh_ddr_stat_addr;
         // no write data on reads, keeps the pipe quiet
         req.wdata <= sh_ddr_stat_wr ? sh_ddr_stat_wdata : '0;
      end
   end

   // ----------------------------------------------------------------------
   // response capture
   // ----------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         ddr_sh_stat_ack   <= 1'b0;
         ddr_sh_stat_rdata <= '0;
         ddr_sh_stat_int   <= '0;
      end
      else
      begin
         ddr_sh_stat_ack   <= rsp.ack;
         // rdata held at zero between acks
         ddr_sh_stat_rdata <= rsp.ack ? rsp.rdata : '0;
         // status follows every cycle
         ddr_sh_stat_int   <= rsp.intr;
      end
   end

endmodule

/* hdl/stat_pipe.sv */
`timescale 1ns/100ps

// fixed latency register chain
// cuts long routes between shell and controller regions
module stat_pipe #(
   parameter int WIDTH  = 8,
   parameter int STAGES = 4
) (
   input  logic             clk,
   input  logic             pipe_rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   generate
      if (STAGES == 0)
      begin : g_bypass
         // zero depth passes the bus straight through
         assign out_bus = in_bus;
      end
      else
      begin : g_chain
         logic [WIDTH-1:0] stage_q [STAGES];

         // all stages cleared by reset
         always_ff @(posedge clk)
         begin
            if (!pipe_rst_n)
            begin
               for (int i = 0; i < STAGES; i++)
                  stage_q[i] <= '0;
            end
            else
            begin
               stage_q[0] <= in_bus;
               // shift toward the output
               for (int i = 1; i < STAGES; i++)
                  stage_q[i] <= stage_q[i-1];
            end
         end

         assign out_bus = stage_q[STAGES-1];
      end
   endgenerate

endmodule

/* hdl/stat_reg_pkg.sv */
`include "stat_defines.svh"

// register map of the DDR status block
package stat_reg_pkg;

   typedef logic [`STAT_ADDR_W-1:0] reg_addr_t;

   // ----------------------------------------------------------------------
   // offsets, byte addressed, word aligned
   // ----------------------------------------------------------------------
   localparam reg_addr_t REG_ID         = 'h00;
   localparam reg_addr_t REG_SCRATCH    = 'h04;
   localparam reg_addr_t REG_READY      = 'h08;
   localparam reg_addr_t REG_WR_COUNT   = 'h0C;
   // read status, write one to clear
   localparam reg_addr_t REG_INT_STATUS = 'h10;
   // write one to set, reads as zero
   localparam reg_addr_t REG_INT_SET    = 'h14;

   // field types
   typedef logic [`STAT_INT_W-1:0]  int_bits_t;
   typedef logic [`DDR_READY_W-1:0] ready_bits_t;

endpackage

/* hdl/stat_req_if.sv */
`timescale 1ns/100ps

`include "stat_defines.svh"

// stat bus request, unpacked form between host port and register block
interface stat_req_if;

   logic                    wr;
   logic                    rd;
   logic [`STAT_ADDR_W-1:0] addr;
   logic [`STAT_DATA_W-1:0] wdata;

   // request issuer
   modport src (
      output wr,
      output rd,
      output addr,
      output wdata
   );

   // request consumer
   modport snk (
      input wr,
      input rd,
      input addr,
      input wdata
   );

endinterface

/* run.sh */
#!/usr/bin/env bash
# build and run the stat path testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f src.f --top-module tb_ddr_stat -Mdir obj_dir -o tb_ddr_stat \
   && ./obj_dir/tb_ddr_stat 2>&1 | tee sim.log \
   || { echo "build or simulation did not complete"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

/* src.f */
+incdir+hdl
hdl/stat_bus_pkg.sv
hdl/stat_reg_pkg.sv
hdl/stat_req_if.sv
hdl/stat_pipe.sv
hdl/stat_host_port.sv
hdl/ddr_stat_regs.sv
hdl/ddr_stat_top.sv
verif/tb_ddr_stat.sv

/* verif/tb_ddr_stat.sv */
`timescale 1ns/100ps

`include "stat_defines.svh"

module tb_ddr_stat;

   // request edge to sampled ack through every register in the loop
   localparam int ACK_LAT  = 2 * `STAT_PIPE_STAGES + 3;
   localparam int WAIT_MAX = 200;

   logic                    clk;
   logic                    pipe_rst_n;
   logic                    sh_ddr_stat_wr;
   logic                    sh_ddr_stat_rd;
   logic [`STAT_ADDR_W-1:0] sh_ddr_stat_addr;
   logic [`STAT_DATA_W-1:0] sh_ddr_stat_wdata;
   logic [`DDR_READY_W-1:0] sh_cl_ddr_is_ready;
   logic                    ddr_sh_stat_ack;
   logic [`STAT_DATA_W-1:0] ddr_sh_stat_rdata;
   logic [`STAT_INT_W-1:0]  ddr_sh_stat_int;

   // reference model state
   logic [`STAT_DATA_W-1:0] m_scratch;
   logic [`STAT_DATA_W-1:0] m_wr_count;
   logic [`STAT_INT_W-1:0]  m_int;
   logic [`STAT_DATA_W-1:0] exp_rdata_q [$];
   logic [`STAT_INT_W-1:0]  exp_int_q [$];
   logic [`STAT_DATA_W-1:0] exp_rdata;
   logic [`STAT_INT_W-1:0]  exp_int;
   logic [ACK_LAT-1:0]      issue_hist;
   logic                    timed_out;
   int                      err_count;
   int                      test_count;
   int                      test_err_base;
   logic [`STAT_DATA_W-1:0] rnd;

   ddr_stat_top u_dut (
      .clk                (clk),
      .pipe_rst_n         (pipe_rst_n),
      .sh_ddr_stat_wr     (sh_ddr_stat_wr),
      .sh_ddr_stat_rd     (sh_ddr_stat_rd),
      .sh_ddr_stat_addr   (sh_ddr_stat_addr),
      .sh_ddr_stat_wdata  (sh_ddr_stat_wdata),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .ddr_sh_stat_ack    (ddr_sh_stat_ack),
      .ddr_sh_stat_rdata  (ddr_sh_stat_rdata),
      .ddr_sh_stat_int    (ddr_sh_stat_int)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // expected ack timing and expected response
   // ----------------------------------------------------------------------
   // one bit per request edge with the oldest at the top
   always @(posedge clk)
   begin
      if (!pipe_rst_n)
         issue_hist <= '0;
      else
         issue_hist <= {issue_hist[ACK_LAT-2:0], sh_ddr_stat_wr | sh_ddr_stat_rd};
   end

   // front of the queue is held through the ack cycle
   always @(negedge clk)
   begin
      if (pipe_rst_n && ddr_sh_stat_ack)
      begin
         if (exp_rdata_q.size() == 0)
         begin
            $display("at %0t an ack arrived with no request outstanding", $time);
            err_count++;
         end
         else
         begin
            exp_rdata <= exp_rdata_q.pop_front();
            exp_int   <= exp_int_q.pop_front();
         end
      end
   end

   task automatic report_mismatch(input string name, input logic [`STAT_DATA_W-1:0] got,
                                  input logic [`STAT_DATA_W-1:0] exp);
      $display("ERROR %0t %s got %08h expected %08h", $time, name, got, exp);
      err_count++;
   endtask

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   ack_timing: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      ddr_sh_stat_ack == issue_hist[ACK_LAT-1])
      else report_mismatch("ddr_sh_stat_ack", {31'd0, $sampled(ddr_sh_stat_ack)},
                           {31'd0, $sampled(issue_hist[ACK_LAT-1])});

   rdata_value: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      ddr_sh_stat_ack |-> ddr_sh_stat_rdata == exp_rdata)
      else report_mismatch("ddr_sh_stat_rdata", $sampled(ddr_sh_stat_rdata),
                           $sampled(exp_rdata));

   // rdata gated off between acks
   rdata_idle: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      !ddr_sh_stat_ack |-> ddr_sh_stat_rdata == '0)
      else report_mismatch("ddr_sh_stat_rdata", $sampled(ddr_sh_stat_rdata), '0);

   int_value: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      ddr_sh_stat_ack |-> ddr_sh_stat_int == exp_int)
      else report_mismatch("ddr_sh_stat_int", {24'd0, $sampled(ddr_sh_stat_int)},
                           {24'd0, $sampled(exp_int)});

   // status only moves in step with a write ack
   int_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      !ddr_sh_stat_ack |-> ddr_sh_stat_int == $past(ddr_sh_stat_int))
      else report_mismatch("ddr_sh_stat_int", {24'd0, $sampled(ddr_sh_stat_int)},
                           {24'd0, $past(ddr_sh_stat_int)});

   // ----------------------------------------------------------------------
   // stimulus and model
   // ----------------------------------------------------------------------
   function automatic logic [`STAT_DATA_W-1:0] expected_read(input logic [7:0] addr);
      case (addr)
         stat_reg_pkg::REG_ID:         return `DDR_STAT_ID;
         stat_reg_pkg::REG_SCRATCH:    return m_scratch;
         stat_reg_pkg::REG_READY:      return {29'd0, sh_cl_ddr_is_ready};
         stat_reg_pkg::REG_WR_COUNT:   return m_wr_count;
         stat_reg_pkg::REG_INT_STATUS: return {24'd0, m_int};
         stat_reg_pkg::REG_INT_SET:    return '0;
         default:                      return `STAT_BAD_DATA;
      endcase
   endfunction

   // one request cycle and its model update in issue order
   task automatic issue(input logic wr, input logic rd, input logic [7:0] addr,
                        input logic [`STAT_DATA_W-1:0] wdata);
      logic [`STAT_DATA_W-1:0] rdata;
      @(negedge clk);
      sh_ddr_stat_wr    = wr;
      sh_ddr_stat_rd    = rd;
      sh_ddr_stat_addr  = addr;
      sh_ddr_stat_wdata = wdata;
      rdata = '0;
      if (wr)
      begin
         m_wr_count = m_wr_count + 32'd1;
         if (addr == stat_reg_pkg::REG_SCRATCH)
            m_scratch = wdata;
         if (addr == stat_reg_pkg::REG_INT_SET)
            m_int = m_int | wdata[7:0];
         if (addr == stat_reg_pkg::REG_INT_STATUS)
            m_int = m_int & ~wdata[7:0];
      end
      else
         rdata = expected_read(addr);
      exp_rdata_q.push_back(rdata);
      exp_int_q.push_back(m_int);
   endtask

   task automatic end_burst();
      @(negedge clk);
      sh_ddr_stat_wr = 1'b0;
      sh_ddr_stat_rd = 1'b0;
   endtask

   // until every outstanding ack has come back
   task automatic wait_idle();
      int n;
      n = 0;
      while (!timed_out && (exp_rdata_q.size() != 0 || issue_hist != '0))
      begin
         if (n == WAIT_MAX)
         begin
            $display("timeout: %0d acks still missing after %0d cycles",
                     exp_rdata_q.size(), WAIT_MAX);
            timed_out = 1'b1;
            err_count++;
         end
         else
         begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic close_test(input string name);
      test_count++;
      $display("test %0d %s done, %0d errors", test_count, name, err_count - test_err_base);
      test_err_base = err_count;
   endtask

   initial
   begin
      rnd                = $urandom(32'h9f27);
      pipe_rst_n         = 1'b0;
      sh_ddr_stat_wr     = 1'b0;
      sh_ddr_stat_rd     = 1'b0;
      sh_ddr_stat_addr   = '0;
      sh_ddr_stat_wdata  = '0;
      sh_cl_ddr_is_ready = '0;
      m_scratch          = '0;
      m_wr_count         = '0;
      m_int              = '0;
      exp_rdata          = '0;
      exp_int            = '0;
      timed_out          = 1'b0;
      err_count          = 0;
      test_count         = 0;
      test_err_base      = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      pipe_rst_n = 1'b1;

      // reset values and then the ID word
      assert (ddr_sh_stat_ack == 1'b0)
      else report_mismatch("ddr_sh_stat_ack", {31'd0, ddr_sh_stat_ack}, '0);
      assert (ddr_sh_stat_rdata == '0)
      else report_mismatch("ddr_sh_stat_rdata", ddr_sh_stat_rdata, '0);
      assert (ddr_sh_stat_int == '0)
      else report_mismatch("ddr_sh_stat_int", {24'd0, ddr_sh_stat_int}, '0);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_ID, '0);
      end_burst();
      wait_idle();
      close_test("reset_and_id");

      // scratch round trip and unmapped reads
      rnd = $urandom;
      issue(1'b1, 1'b0, stat_reg_pkg::REG_SCRATCH, rnd);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_SCRATCH, '0);
      issue(1'b0, 1'b1, 8'h40, '0);
      issue(1'b0, 1'b1, 8'hfc, '0);
      end_burst();
      wait_idle();
      close_test("scratch_and_unmapped");

      // ready held steady while each read is in flight
      for (int i = 0; i < 4; i++)
      begin
         rnd = $urandom;
         @(negedge clk);
         sh_cl_ddr_is_ready = rnd[2:0];
         issue(1'b0, 1'b1, stat_reg_pkg::REG_READY, '0);
         end_burst();
         wait_idle();
      end
      // a write to a read-only register still counts
      issue(1'b1, 1'b0, stat_reg_pkg::REG_ID, $urandom);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_WR_COUNT, '0);
      end_burst();
      wait_idle();
      close_test("ready_and_wr_count");

      // set bits and read back then set more and clear a mask before the last reads
      rnd = $urandom;
      issue(1'b1, 1'b0, stat_reg_pkg::REG_INT_SET, {24'd0, rnd[7:0]});
      issue(1'b0, 1'b1, stat_reg_pkg::REG_INT_STATUS, '0);
      issue(1'b1, 1'b0, stat_reg_pkg::REG_INT_SET, {24'd0, rnd[15:8]});
      issue(1'b1, 1'b0, stat_reg_pkg::REG_INT_STATUS, {24'd0, rnd[23:16]});
      issue(1'b0, 1'b1, stat_reg_pkg::REG_INT_STATUS, '0);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_INT_SET, '0);
      end_burst();
      wait_idle();
      close_test("interrupts");

      // back to back requests with wr and rd together acting as a write
      issue(1'b1, 1'b0, stat_reg_pkg::REG_SCRATCH, $urandom);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_SCRATCH, '0);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_ID, '0);
      issue(1'b1, 1'b1, stat_reg_pkg::REG_SCRATCH, $urandom);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_SCRATCH, '0);
      issue(1'b0, 1'b1, stat_reg_pkg::REG_WR_COUNT, '0);
      end_burst();
      wait_idle();
      close_test("pipelining_and_priority");

      $display("tests run %0d, errors %0d", test_count, err_count);
      if (err_count == 0)
      begin
         $display("TESTBENCH PASSED");
      end
      else
      begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
